//--- rtl/hps_link_macros.svh
// widths and counts shared by the link RTL and testbench, pulled in with `include
`ifndef HPS_LINK_MACROS_SVH
`define HPS_LINK_MACROS_SVH

// bus word width
`define HPS_WORD_W 16

// word counter width, the counter saturates at all ones
`define HPS_IDX_W 10

// joysticks served by the settings registers
`define HPS_JOY_NUM 6

// high byte of a keyboard word that marks the rest of the frame as skipped
`define HPS_SKIP_MARK 8'hFF

`endif

//--- rtl/hps_cmd_pkg.sv
// opcode and frame state types of the host command protocol, imported by RTL and testbench
`include "hps_link_macros.svh"

package hps_cmd_pkg;

	// opcode carried by word 0 of every frame
	typedef enum logic [`HPS_WORD_W-1:0] {
		CMD_NONE       = 16'h0000,
		CMD_CFG        = 16'h0001,
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_KBD        = 16'h0005,
		CMD_JOY2       = 16'h0010,
		CMD_JOY3       = 16'h0011,
		CMD_JOY4       = 16'h0012,
		CMD_JOY5       = 16'h0013,
		CMD_STATUS     = 16'h001E,
		CMD_KBD_LED    = 16'h001F,
		CMD_STATUS_REQ = 16'h0029,
		CMD_MENUMASK   = 16'h002E
	} hps_cmd_t;

	// framing of the host bus
	typedef enum logic [1:0] {
		FRAME_IDLE,
		FRAME_CMD,
		FRAME_DATA
	} frame_state_t;

endpackage

//--- rtl/hps_data_pkg.sv
// payload types carried over the host link, imported by RTL and testbench
`include "hps_link_macros.svh"

package hps_data_pkg;

	typedef logic [`HPS_WORD_W-1:0] hps_word_t;
	typedef logic [`HPS_IDX_W-1:0]  word_idx_t;

	// one joystick, low half written by word 1
	typedef logic [31:0] joy_t;

	typedef logic [63:0] status_t;

	// keyboard event as seen by the core
	// toggle flips on every published event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

endpackage

//--- rtl/host_link.sv
// frames the host bus for both decoders and registers the combined reply word
module host_link
	import hps_cmd_pkg::*;
	import hps_data_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      io_enable,
	input  logic      io_strobe,
	input  hps_word_t io_din,
	output hps_cmd_t  cmd,
	output word_idx_t word_idx,
	output logic      data_stb,
	output logic      frame_end,
	input  hps_word_t set_reply,
	input  hps_word_t key_reply,
	output hps_word_t io_dout
);

	frame_state_t state;
	hps_cmd_t     cmd_q;
	logic         enable_d;

	assign data_stb = io_enable & io_strobe & (state == FRAME_DATA);

	// word 0 decodes straight from the bus, later words use the stored opcode
	assign cmd = (state == FRAME_DATA) ? cmd_q : hps_cmd_t'(io_din);

	////////////////////////////////////////
	// frame tracking

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state    <= FRAME_IDLE;
			cmd_q    <= CMD_NONE;
			word_idx <= '0;
		end else if (!io_enable) begin
			state    <= FRAME_IDLE;
			cmd_q    <= CMD_NONE;
			word_idx <= '0;
		end else begin
			case (state)
				FRAME_IDLE: state <= io_strobe ? FRAME_DATA : FRAME_CMD;
				FRAME_CMD:  if (io_strobe) state <= FRAME_DATA;
				FRAME_DATA: state <= FRAME_DATA;
				default:    state <= FRAME_IDLE;
			endcase
			if (io_strobe && state != FRAME_DATA)
				cmd_q <= hps_cmd_t'(io_din);
			// saturate so long frames keep hitting the last index
			if (io_strobe && !(&word_idx))
				word_idx <= word_idx + 1'b1;
		end
	end

	////////////////////////////////////////
	// frame end pulse and reply register

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			enable_d  <= 1'b0;
			frame_end <= 1'b0;
			io_dout   <= '0;
		end else begin
			enable_d  <= io_enable;
			frame_end <= enable_d & ~io_enable;
			// unclaimed words read back as 0
			if (!io_enable)
				io_dout <= '0;
			else if (io_strobe)
				io_dout <= set_reply | key_reply;
		end
	end

endmodule

//--- rtl/settings_regs.sv
// settings registers written by the host, plus status request capture and readback
`include "hps_link_macros.svh"

module settings_regs
	import hps_cmd_pkg::*;
	import hps_data_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  hps_cmd_t   cmd,
	input  word_idx_t  word_idx,
	input  logic       data_stb,
	input  hps_word_t  io_din,
	input  status_t    status_in,
	input  logic       status_set,
	input  hps_word_t  status_menumask,
	output logic [7:0] cfg,
	output joy_t       joystick [`HPS_JOY_NUM],
	output status_t    status,
	output hps_word_t  set_reply
);

	logic [2:0] joy_sel;
	logic       joy_hit;
	logic       quad_hit;
	logic [1:0] quad_sel;
	logic       status_set_d;
	logic [3:0] stflg;
	status_t    status_req;

	// words 1 to 4 select a 16 bit quarter of a status word
	assign quad_hit = (word_idx >= word_idx_t'(1)) && (word_idx <= word_idx_t'(4));
	assign quad_sel = 2'(word_idx - word_idx_t'(1));

	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 3'd0;
		case (cmd)
			CMD_JOY0: joy_sel = 3'd0;
			CMD_JOY1: joy_sel = 3'd1;
			CMD_JOY2: joy_sel = 3'd2;
			CMD_JOY3: joy_sel = 3'd3;
			CMD_JOY4: joy_sel = 3'd4;
			CMD_JOY5: joy_sel = 3'd5;
			default:  joy_hit = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// host writes

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg    <= '0;
			status <= '0;
			for (int i = 0; i < `HPS_JOY_NUM; i++)
				joystick[i] <= '0;
		end else if (data_stb) begin
			if (cmd == CMD_CFG)
				cfg <= io_din[7:0];
			// word 1 is the low half, anything after it the high half
			if (joy_hit) begin
				if (word_idx == word_idx_t'(1))
					joystick[joy_sel][15:0] <= io_din;
				else
					joystick[joy_sel][31:16] <= io_din;
			end
			if (cmd == CMD_STATUS && quad_hit)
				status[{quad_sel, 4'b0000} +: 16] <= io_din;
		end
	end

	// core side status request, counted so the host sees every change
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_d <= 1'b0;
			stflg        <= '0;
			status_req   <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				stflg      <= stflg + 4'd1;
				status_req <= status_in;
			end
		end
	end

	////////////////////////////////////////
	// readback

	always_comb begin
		set_reply = '0;
		case (cmd)
			CMD_STATUS_REQ: begin
				if (word_idx == '0)
					set_reply = {8'h00, 4'hA, stflg};
				else if (quad_hit)
					set_reply = status_req[{quad_sel, 4'b0000} +: 16];
			end
			CMD_MENUMASK: if (word_idx == word_idx_t'(1)) set_reply = status_menumask;
			default: ;
		endcase
	end

endmodule

//--- rtl/key_events.sv
// turns keyboard scan bytes from the host into key events and returns the LED state
`include "hps_link_macros.svh"

module key_events
	import hps_cmd_pkg::*;
	import hps_data_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  hps_cmd_t   cmd,
	input  word_idx_t  word_idx,
	input  logic       data_stb,
	input  logic       frame_end,
	input  hps_word_t  io_din,
	input  logic [2:0] kbd_led_status,
	input  logic [2:0] kbd_led_use,
	output key_event_t ps2_key,
	output hps_word_t  key_reply
);

	logic [31:0] raw;
	logic        skip;
	logic        kbd_frame;
	logic        frame_start;
	logic        pressed;
	logic        extended;
	key_event_t  key_next;

	// opcode taken, first scan byte not yet in
	assign frame_start = (cmd == CMD_KBD) && (word_idx == word_idx_t'(1)) && !data_stb;

	assign pressed  = (raw[15:8] != 8'hF0);
	assign extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);

	always_comb begin
		key_next.toggle   = ~ps2_key.toggle;
		key_next.pressed  = pressed;
		key_next.extended = extended;
		key_next.code     = raw[7:0];
		// print screen and pause don't fit the two byte rule
		case (raw)
			32'hE012E07C: {key_next.pressed, key_next.extended, key_next.code} = 10'h37C;
			32'h7CE0F012: {key_next.pressed, key_next.extended, key_next.code} = 10'h17C;
			32'hF014F077: {key_next.pressed, key_next.extended, key_next.code} = 10'h377;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			raw       <= '0;
			skip      <= 1'b0;
			kbd_frame <= 1'b0;
			ps2_key   <= '0;
		end else begin
			if (frame_start) begin
				raw       <= '0;
				skip      <= 1'b0;
				kbd_frame <= 1'b1;
			end else if (data_stb && cmd == CMD_KBD) begin
				if (io_din[15:8] == `HPS_SKIP_MARK)
					skip <= 1'b1;
				else if (!skip)
					raw <= {raw[23:0], io_din[7:0]};
			end
			if (frame_end) begin
				kbd_frame <= 1'b0;
				if (kbd_frame && !skip)
					ps2_key <= key_next;
			end
		end
	end

	// LED readback, status and use interleaved from bit 2 down
	always_comb begin
		key_reply = '0;
		if (cmd == CMD_KBD_LED && word_idx != '0)
			key_reply = {7'd0, 1'b0, 2'b01,
				kbd_led_status[2], kbd_led_use[2],
				kbd_led_status[1], kbd_led_use[1],
				kbd_led_status[0], kbd_led_use[0]};
	end

endmodule

//--- rtl/hps_link_top.sv
// top of the host command link, connects the bus framer to the settings and key decoders
`include "hps_link_macros.svh"

module hps_link_top
	import hps_cmd_pkg::*;
	import hps_data_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  hps_word_t  io_din,
	output hps_word_t  io_dout,
	input  status_t    status_in,
	input  logic       status_set,
	input  hps_word_t  status_menumask,
	input  logic [2:0] kbd_led_status,
	input  logic [2:0] kbd_led_use,
	output logic [7:0] cfg,
	output joy_t       joystick [`HPS_JOY_NUM],
	output status_t    status,
	output key_event_t ps2_key
);

	hps_cmd_t  cmd;
	word_idx_t word_idx;
	logic      data_stb;
	logic      frame_end;
	hps_word_t set_reply;
	hps_word_t key_reply;

	////////////////////////////////////////
	// bus framing

	host_link u_host_link (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.cmd       (cmd),
		.word_idx  (word_idx),
		.data_stb  (data_stb),
		.frame_end (frame_end),
		.set_reply (set_reply),
		.key_reply (key_reply),
		.io_dout   (io_dout)
	);

	////////////////////////////////////////
	// decoders, both see every word

	settings_regs u_settings_regs (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cmd             (cmd),
		.word_idx        (word_idx),
		.data_stb        (data_stb),
		.io_din          (io_din),
		.status_in       (status_in),
		.status_set      (status_set),
		.status_menumask (status_menumask),
		.cfg             (cfg),
		.joystick        (joystick),
		.status          (status),
		.set_reply       (set_reply)
	);

	key_events u_key_events (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cmd            (cmd),
		.word_idx       (word_idx),
		.data_stb       (data_stb),
		.frame_end      (frame_end),
		.io_din         (io_din),
		.kbd_led_status (kbd_led_status),
		.kbd_led_use    (kbd_led_use),
		.ps2_key        (ps2_key),
		.key_reply      (key_reply)
	);

endmodule

//--- tb/tb_clock.sv
// clock and reset source for the testbench, 100 ns period with reset held for 8 cycles
module tb_clock (
	output logic clk_sys,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

//--- tb/hps_link_assertions.sv
// protocol assertions on the host bus framer, attached to host_link by bind
module hps_link_assertions
	import hps_data_pkg::*;
(
	input logic      clk_sys,
	input logic      reset,
	input logic      io_enable,
	input logic      io_strobe,
	input logic      frame_end,
	input logic      data_stb,
	input hps_word_t io_dout,
	input word_idx_t word_idx
);
	timeunit 1ns;
	timeprecision 100ps;

	// failures seen so far, read by the testbench summary
	int failures = 0;

	a_strobe_in_frame: assert property (@(posedge clk_sys) disable iff (reset)
		io_strobe |-> io_enable)
		else begin
			failures++;
			$error("io_strobe pulsed while io_enable was low");
		end

	a_frame_end_width: assert property (@(posedge clk_sys) disable iff (reset)
		frame_end |=> !frame_end)
		else begin
			failures++;
			$error("frame_end stayed high for more than one cycle");
		end

	// enable high two edges back and low on the last edge
	a_frame_end_after_fall: assert property (@(posedge clk_sys) disable iff (reset)
		frame_end |-> ($past(io_enable, 2) && !$past(io_enable)))
		else begin
			failures++;
			$error("frame_end without a preceding fall of io_enable");
		end

	a_dout_cleared: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(io_enable) |=> (io_dout == '0))
		else begin
			failures++;
			$error("io_dout not cleared one cycle after the frame ended");
		end

	// the opcode word sits at index 0, data strobes only come after it
	a_no_data_in_cmd: assert property (@(posedge clk_sys) disable iff (reset)
		data_stb |-> (word_idx != '0))
		else begin
			failures++;
			$error("data_stb raised while waiting for the opcode word");
		end

endmodule

bind host_link hps_link_assertions u_assertions (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.io_enable (io_enable),
	.io_strobe (io_strobe),
	.frame_end (frame_end),
	.data_stb  (data_stb),
	.io_dout   (io_dout),
	.word_idx  (word_idx)
);

//--- tb/tb_hps_link.sv
// directed testbench for the host command link, compiled as the simulation top
`include "hps_link_macros.svh"

module tb_hps_link
	import hps_cmd_pkg::*;
	import hps_data_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// well above the length of all directed tests
	localparam int MAX_CYCLES = 4000;
	localparam int FRAME_MAX  = 8;
	localparam hps_cmd_t JOY_CMDS [`HPS_JOY_NUM] = '{
		CMD_JOY0, CMD_JOY1, CMD_JOY2, CMD_JOY3, CMD_JOY4, CMD_JOY5
	};

	logic       clk_sys;
	logic       reset;
	logic       io_enable;
	logic       io_strobe;
	hps_word_t  io_din;
	hps_word_t  io_dout;
	status_t    status_in;
	logic       status_set;
	hps_word_t  status_menumask;
	logic [2:0] kbd_led_status;
	logic [2:0] kbd_led_use;
	logic [7:0] cfg;
	joy_t       joystick [`HPS_JOY_NUM];
	status_t    status;
	key_event_t ps2_key;

	hps_word_t  tx_words [FRAME_MAX];
	hps_word_t  rx_words [FRAME_MAX];
	int         value_errors;
	int         cycles;
	key_event_t key_model;

	tb_clock u_clock (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	hps_link_top dut (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.io_enable       (io_enable),
		.io_strobe       (io_strobe),
		.io_din          (io_din),
		.io_dout         (io_dout),
		.status_in       (status_in),
		.status_set      (status_set),
		.status_menumask (status_menumask),
		.kbd_led_status  (kbd_led_status),
		.kbd_led_use     (kbd_led_use),
		.cfg             (cfg),
		.joystick        (joystick),
		.status          (status),
		.ps2_key         (ps2_key)
	);

	////////////////////////////////////////
	// compare tasks

	task automatic check_word(input string name, input hps_word_t got, input hps_word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_joy(input string name, input joy_t got, input joy_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input status_t got, input status_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_key(input string name, input key_event_t got, input key_event_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	////////////////////////////////////////
	// bus driver and helpers

	// one word per two cycles, replies sampled at the falling edge after their strobe
	task automatic send_frame(input int len);
		int i;
		@(posedge clk_sys);
		io_enable <= 1'b1;
		for (i = 0; i < len; i++) begin
			@(posedge clk_sys);
			io_strobe <= 1'b1;
			io_din    <= tx_words[i];
			@(posedge clk_sys);
			io_strobe <= 1'b0;
			@(negedge clk_sys);
			rx_words[i] = io_dout;
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		io_din    <= '0;
		// frame_end then the key event, one edge each
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic pulse_status_set(input status_t value);
		@(posedge clk_sys);
		status_in  <= value;
		status_set <= 1'b1;
		@(posedge clk_sys);
		status_set <= 1'b0;
	endtask

	task automatic read_status_request(input hps_word_t exp_flag, input status_t exp_val);
		int i;
		tx_words[0] = CMD_STATUS_REQ;
		for (i = 1; i < 5; i++)
			tx_words[i] = '0;
		send_frame(5);
		check_word("io_dout status request word 0", rx_words[0], exp_flag);
		for (i = 1; i < 5; i++)
			check_word($sformatf("io_dout status request word %0d", i), rx_words[i],
				hps_word_t'(exp_val >> (16 * (i - 1))));
	endtask

	// every event inverts the toggle bit
	task automatic expect_key(input logic pressed, input logic extended, input logic [7:0] code);
		key_model.toggle   = ~key_model.toggle;
		key_model.pressed  = pressed;
		key_model.extended = extended;
		key_model.code     = code;
		check_key("ps2_key", ps2_key, key_model);
	endtask

	// marker 01 above status and use bits interleaved from bit 2 down
	function automatic hps_word_t led_reply(input logic [2:0] st, input logic [2:0] used);
		return {8'h00, 2'b01, st[2], used[2], st[1], used[1], st[0], used[0]};
	endfunction

	////////////////////////////////////////
	// directed tests

	task automatic test_reset();
		int i;
		check_word("io_dout", io_dout, '0);
		check_word("cfg", {8'h00, cfg}, '0);
		check_status("status", status, '0);
		check_key("ps2_key", ps2_key, '0);
		for (i = 0; i < `HPS_JOY_NUM; i++)
			check_joy($sformatf("joystick[%0d]", i), joystick[i], '0);
	endtask

	task automatic test_settings();
		joy_t        joy_exp [`HPS_JOY_NUM];
		status_t     st_exp;
		logic [31:0] rnd;
		int          i;
		for (i = 0; i < `HPS_JOY_NUM; i++) begin
			joy_exp[i]  = $urandom();
			tx_words[0] = JOY_CMDS[i];
			tx_words[1] = joy_exp[i][15:0];
			tx_words[2] = joy_exp[i][31:16];
			send_frame(3);
		end
		st_exp      = {$urandom(), $urandom()};
		tx_words[0] = CMD_STATUS;
		for (i = 1; i < 5; i++)
			tx_words[i] = hps_word_t'(st_exp >> (16 * (i - 1)));
		send_frame(5);
		rnd         = $urandom();
		tx_words[0] = CMD_CFG;
		tx_words[1] = rnd[15:0];
		send_frame(2);
		for (i = 0; i < `HPS_JOY_NUM; i++)
			check_joy($sformatf("joystick[%0d]", i), joystick[i], joy_exp[i]);
		check_status("status", status, st_exp);
		check_word("cfg", {8'h00, cfg}, {8'h00, rnd[7:0]});
	endtask

	task automatic test_status_request();
		status_t     req_val;
		logic [31:0] rnd;
		req_val = {$urandom(), $urandom()};
		pulse_status_set(req_val);
		read_status_request(16'h00A1, req_val);
		req_val = {$urandom(), $urandom()};
		pulse_status_set(req_val);
		read_status_request(16'h00A2, req_val);
		rnd = $urandom();
		@(posedge clk_sys);
		status_menumask <= rnd[15:0];
		tx_words[0] = CMD_MENUMASK;
		tx_words[1] = '0;
		send_frame(2);
		check_word("io_dout menu mask", rx_words[1], rnd[15:0]);
		// opcode outside the command set
		tx_words[0] = 16'h0077;
		tx_words[1] = 16'h1234;
		tx_words[2] = 16'h5678;
		send_frame(3);
		check_word("io_dout unknown word 0", rx_words[0], '0);
		check_word("io_dout unknown word 1", rx_words[1], '0);
		check_word("io_dout unknown word 2", rx_words[2], '0);
	endtask

	task automatic test_keys();
		tx_words[0] = CMD_KBD;
		tx_words[1] = 16'h001C;
		send_frame(2);
		expect_key(1'b1, 1'b0, 8'h1C);
		tx_words[1] = 16'h00F0;
		tx_words[2] = 16'h001C;
		send_frame(3);
		expect_key(1'b0, 1'b0, 8'h1C);
		tx_words[1] = 16'h00E0;
		tx_words[2] = 16'h0075;
		send_frame(3);
		expect_key(1'b1, 1'b1, 8'h75);
		// print screen press
		tx_words[1] = 16'h00E0;
		tx_words[2] = 16'h0012;
		tx_words[3] = 16'h00E0;
		tx_words[4] = 16'h007C;
		send_frame(5);
		expect_key(1'b1, 1'b1, 8'h7C);
	endtask

	task automatic test_skip_and_leds();
		logic [31:0] rnd;
		int          i;
		tx_words[0] = CMD_KBD;
		tx_words[1] = {`HPS_SKIP_MARK, 8'h00};
		tx_words[2] = 16'h001C;
		send_frame(3);
		check_key("ps2_key after skip", ps2_key, key_model);
		for (i = 0; i < 4; i++) begin
			rnd = $urandom();
			@(posedge clk_sys);
			kbd_led_status <= rnd[2:0];
			kbd_led_use    <= rnd[5:3];
			tx_words[0] = CMD_KBD_LED;
			tx_words[1] = '0;
			send_frame(2);
			check_word("io_dout led word 0", rx_words[0], '0);
			check_word("io_dout led word 1", rx_words[1], led_reply(rnd[2:0], rnd[5:3]));
		end
	endtask

	////////////////////////////////////////
	// run control

	initial begin
		void'($urandom(13));
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		kbd_led_status  = '0;
		kbd_led_use     = '0;
		value_errors    = 0;
		key_model       = '0;
		@(negedge reset);
		@(negedge clk_sys);
		test_reset();
		test_settings();
		test_status_request();
		test_keys();
		test_skip_and_leds();
		$display("errors: %0d value mismatches, %0d assertion failures",
			value_errors, dut.u_host_link.u_assertions.failures);
		if (value_errors == 0 && dut.u_host_link.u_assertions.failures == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycles);
		$display("errors: %0d value mismatches, %0d assertion failures",
			value_errors, dut.u_host_link.u_assertions.failures);
		$display("tests failed");
		$finish;
	end

endmodule

//--- hps_link.f
+incdir+rtl
rtl/hps_cmd_pkg.sv
rtl/hps_data_pkg.sv
rtl/host_link.sv
rtl/settings_regs.sv
rtl/key_events.sv
rtl/hps_link_top.sv
tb/tb_clock.sv
tb/hps_link_assertions.sv
tb/tb_hps_link.sv

//--- Makefile
TOP             ?= tb_hps_link
FILELIST        ?= hps_link.f
LOG             ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --assert
SIM_FLAGS       ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) $(SIM_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "all tests passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
